//--- rtl/pwo_config.svh
// Build constants for the pointwise engine, fixed to ML-DSA (q = 8380417)
// Lane layout assumes PWO_REG_W is PWO_COEFF_W plus one zero pad bit

`ifndef PWO_CONFIG_SVH
`define PWO_CONFIG_SVH

// Modulus, sized to the coefficient width
`define PWO_Q 23'd8380417

// Bits of one reduced coefficient
`define PWO_COEFF_W 23

// Bits of one lane in a memory word
`define PWO_REG_W 24

// Coefficients packed into one memory word
`define PWO_LANES 4

// Memory words per polynomial of 256 coefficients
`define PWO_WORDS 64

`define PWO_ADDR_W 15

`endif

//--- rtl/pwo_pkg.sv
// Shared types of the pointwise engine
// Widths follow pwo_config.svh, enum encodings are fixed at 2 bits

`default_nettype none

`include "pwo_config.svh"

package pwo_pkg;

    // ==========================================================================
    // Vector types
    // ==========================================================================

    typedef logic [`PWO_COEFF_W-1:0] coeff_t;
    typedef logic [`PWO_ADDR_W-1:0] mem_addr_t;
    // Lane i sits in bits 24i to 24i+22, bit 24i+23 stays zero
    typedef logic [`PWO_LANES*`PWO_REG_W-1:0] mem_word_t;
    typedef logic [$clog2(`PWO_WORDS)-1:0] word_idx_t;

    // ==========================================================================
    // Enums
    // ==========================================================================

    typedef enum logic [1:0] {
        pwm = 2'd0,
        pwa = 2'd1,
        pws = 2'd2
    } pwo_mode_t;

    typedef enum logic [1:0] {
        rw_idle  = 2'd0,
        rw_read  = 2'd1,
        rw_write = 2'd2
    } rw_t;

    typedef enum logic [1:0] {
        seq_idle  = 2'd0,
        seq_run   = 2'd1,
        seq_drain = 2'd2
    } seq_state_t;

    // ==========================================================================
    // Structs
    // ==========================================================================

    // Memory request, one per port
    typedef struct packed {
        rw_t       rd_wr_en;
        mem_addr_t addr;
    } mem_req_t;

    // Operation latched at start
    typedef struct packed {
        pwo_mode_t mode;
        logic      accumulate;
    } pwo_op_t;

    // Word issue tag, carried from decode to result
    typedef struct packed {
        logic      strobe;
        word_idx_t idx;
        logic      last;
    } issue_t;

endpackage

`default_nettype wire

//--- rtl/pwo_decode.sv
// Sequencer for one pointwise run over a 64 word polynomial
// Mode, accumulate and base addresses must stay stable while busy_o is high
// Read requests are combinational on sampler_valid_i during seq_run

`timescale 1ns/10ps
`default_nettype none

`include "pwo_config.svh"

module pwo_decode (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 zeroize_i,
    input  wire                 enable_i,
    input  pwo_pkg::pwo_mode_t  mode_i,
    input  wire                 accumulate_i,
    input  wire                 sampler_valid_i,
    input  pwo_pkg::mem_addr_t  a_base_i,
    input  pwo_pkg::mem_addr_t  b_base_i,
    input  pwo_pkg::mem_addr_t  c_base_i,
    output pwo_pkg::mem_req_t   a_rd_req_o,
    output pwo_pkg::mem_req_t   b_rd_req_o,
    output pwo_pkg::mem_req_t   c_rd_req_o,
    output pwo_pkg::pwo_op_t    op_o,
    output pwo_pkg::issue_t     issue_o,
    output logic                busy_o,
    input  wire                 retire_i
);

    pwo_pkg::seq_state_t state_q;
    pwo_pkg::seq_state_t state_d;
    pwo_pkg::word_idx_t  idx_q;
    pwo_pkg::pwo_op_t    op_q;
    logic                issue;
    logic                last;
    logic                rd_c;

    assign issue = (state_q == pwo_pkg::seq_run) && sampler_valid_i;
    assign last  = (idx_q == pwo_pkg::word_idx_t'(`PWO_WORDS - 1));
    // Old destination value only needed for accumulate
    assign rd_c  = issue && (op_q.mode == pwo_pkg::pwm) && op_q.accumulate;

    always_comb begin
        state_d = state_q;
        case (state_q)
            pwo_pkg::seq_idle:  if (enable_i) state_d = pwo_pkg::seq_run;
            pwo_pkg::seq_run:   if (issue && last) state_d = pwo_pkg::seq_drain;
            // Wait for the last write to leave the result stage
            pwo_pkg::seq_drain: if (retire_i) state_d = pwo_pkg::seq_idle;
            default:            state_d = pwo_pkg::seq_idle;
        endcase
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state_q <= pwo_pkg::seq_idle;
            idx_q   <= '0;
            op_q    <= '0;
        end else if (zeroize_i) begin
            state_q <= pwo_pkg::seq_idle;
            idx_q   <= '0;
            op_q    <= '0;
        end else begin
            state_q <= state_d;
            if ((state_q == pwo_pkg::seq_idle) && enable_i) begin
                op_q.mode       <= mode_i;
                op_q.accumulate <= accumulate_i;
                idx_q           <= '0;
            end else if (issue) begin
                // Wraps to zero after the last word
                idx_q <= idx_q + pwo_pkg::word_idx_t'(1);
            end
        end
    end

    // ==========================================================================
    // Requests and issue tag
    // ==========================================================================

    assign a_rd_req_o.rd_wr_en = issue ? pwo_pkg::rw_read : pwo_pkg::rw_idle;
    assign a_rd_req_o.addr     = a_base_i + pwo_pkg::mem_addr_t'(idx_q);
    assign b_rd_req_o.rd_wr_en = issue ? pwo_pkg::rw_read : pwo_pkg::rw_idle;
    assign b_rd_req_o.addr     = b_base_i + pwo_pkg::mem_addr_t'(idx_q);
    assign c_rd_req_o.rd_wr_en = rd_c ? pwo_pkg::rw_read : pwo_pkg::rw_idle;
    assign c_rd_req_o.addr     = c_base_i + pwo_pkg::mem_addr_t'(idx_q);

    assign issue_o.strobe = issue;
    assign issue_o.idx    = idx_q;
    assign issue_o.last   = issue && last;

    assign op_o   = op_q;
    assign busy_o = (state_q != pwo_pkg::seq_idle);

    // Accumulate only makes sense for pwm
    a_acc_only_pwm: assert property (@(posedge clk) disable iff (!reset_n)
        (busy_o && op_q.accumulate) |-> (op_q.mode == pwo_pkg::pwm))
        else $error("accumulate latched with pwa or pws");

    // Sequencer leaves seq_run right after the 64th issue
    a_no_read_after_last: assert property (@(posedge clk) disable iff (!reset_n)
        issue_o.last |=> ((a_rd_req_o.rd_wr_en == pwo_pkg::rw_idle) &&
                          (b_rd_req_o.rd_wr_en == pwo_pkg::rw_idle) &&
                          (c_rd_req_o.rd_wr_en == pwo_pkg::rw_idle)))
        else $error("read request after the last issue of a run");

endmodule

`default_nettype wire

//--- rtl/pwo_execute.sv
// Four lane pointwise arithmetic, result valid three cycles after issue
// Two register stages, the final reduction is combinational into the write
// Operands must already be reduced below q

`timescale 1ns/10ps
`default_nettype none

`include "pwo_config.svh"

module pwo_execute (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 zeroize_i,
    input  pwo_pkg::pwo_op_t    op_i,
    input  pwo_pkg::mem_word_t  a_data_i,
    input  pwo_pkg::mem_word_t  b_data_i,
    input  pwo_pkg::mem_word_t  c_data_i,
    output pwo_pkg::mem_word_t  result_o
);

    localparam int WIDE_W = 2 * `PWO_COEFF_W;
    localparam logic [WIDE_W-1:0] Q_WIDE = WIDE_W'(`PWO_Q);
    localparam pwo_pkg::coeff_t Q_COEFF = `PWO_Q;
    localparam logic [`PWO_COEFF_W:0] Q_SUM = {1'b0, Q_COEFF};

    logic use_c;

    // c enters only for pwm with accumulate
    assign use_c = (op_i.mode == pwo_pkg::pwm) && op_i.accumulate;

    for (genvar i = 0; i < `PWO_LANES; i++) begin : g_lane
        pwo_pkg::coeff_t       a_s1_q;
        pwo_pkg::coeff_t       b_s1_q;
        pwo_pkg::coeff_t       c_s1_q;
        pwo_pkg::coeff_t       c_s2_q;
        logic [WIDE_W-1:0]     wide_s2_q;
        pwo_pkg::coeff_t       red1;
        logic [`PWO_COEFF_W:0] acc_sum;
        pwo_pkg::coeff_t       lane_res;

        always_ff @(posedge clk or negedge reset_n) begin
            if (!reset_n) begin
                a_s1_q    <= '0;
                b_s1_q    <= '0;
                c_s1_q    <= '0;
                c_s2_q    <= '0;
                wide_s2_q <= '0;
            end else if (zeroize_i) begin
                a_s1_q    <= '0;
                b_s1_q    <= '0;
                c_s1_q    <= '0;
                c_s2_q    <= '0;
                wide_s2_q <= '0;
            end else begin
                // Stage 1, lane operands
                a_s1_q <= a_data_i[i*`PWO_REG_W +: `PWO_COEFF_W];
                b_s1_q <= b_data_i[i*`PWO_REG_W +: `PWO_COEFF_W];
                c_s1_q <= use_c ? c_data_i[i*`PWO_REG_W +: `PWO_COEFF_W] : '0;
                // Stage 2, full product or sum or difference
                c_s2_q <= c_s1_q;
                case (op_i.mode)
                    pwo_pkg::pwm: wide_s2_q <= WIDE_W'(a_s1_q) * WIDE_W'(b_s1_q);
                    pwo_pkg::pwa: wide_s2_q <= WIDE_W'(a_s1_q) + WIDE_W'(b_s1_q);
                    // Two's complement, MSB marks a negative difference
                    default:      wide_s2_q <= WIDE_W'(a_s1_q) - WIDE_W'(b_s1_q);
                endcase
            end
        end

        // Stage 3, reduce, add c, reduce again
        always_comb begin
            red1    = pwo_pkg::coeff_t'(wide_s2_q % Q_WIDE);
            acc_sum = {1'b0, red1} + {1'b0, c_s2_q};
            if (op_i.mode == pwo_pkg::pws) begin
                if (wide_s2_q[WIDE_W-1]) begin
                    lane_res = wide_s2_q[`PWO_COEFF_W-1:0] + Q_COEFF;
                end else begin
                    lane_res = wide_s2_q[`PWO_COEFF_W-1:0];
                end
            end else if (acc_sum >= Q_SUM) begin
                lane_res = pwo_pkg::coeff_t'(acc_sum - Q_SUM);
            end else begin
                lane_res = pwo_pkg::coeff_t'(acc_sum);
            end
        end

        assign result_o[i*`PWO_REG_W +: `PWO_REG_W] = {1'b0, lane_res};

        a_lane_below_q: assert property (@(posedge clk) disable iff (!reset_n)
            !$isunknown(lane_res) |-> (lane_res < Q_COEFF))
            else $error("lane %0d result not below q", i);
    end

endmodule

`default_nettype wire

//--- rtl/pwo_result.sv
// Write alignment and run completion
// Write request leaves exactly three cycles after its issue

`timescale 1ns/10ps
`default_nettype none

module pwo_result (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 zeroize_i,
    input  pwo_pkg::issue_t     issue_i,
    input  pwo_pkg::mem_addr_t  c_base_i,
    input  pwo_pkg::mem_word_t  result_i,
    output pwo_pkg::mem_req_t   wr_req_o,
    output pwo_pkg::mem_word_t  wr_data_o,
    output logic                retire_o,
    output logic                done_o
);

    // Delay line matching the execute latency
    pwo_pkg::issue_t dly_q [3];
    pwo_pkg::issue_t out_tag;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            dly_q[0] <= '0;
            dly_q[1] <= '0;
            dly_q[2] <= '0;
            done_o   <= 1'b0;
        end else if (zeroize_i) begin
            dly_q[0] <= '0;
            dly_q[1] <= '0;
            dly_q[2] <= '0;
            done_o   <= 1'b0;
        end else begin
            dly_q[0] <= issue_i;
            dly_q[1] <= dly_q[0];
            dly_q[2] <= dly_q[1];
            done_o   <= retire_o;
        end
    end

    assign out_tag = dly_q[2];

    assign wr_req_o.rd_wr_en = out_tag.strobe ? pwo_pkg::rw_write : pwo_pkg::rw_idle;
    assign wr_req_o.addr     = c_base_i + pwo_pkg::mem_addr_t'(out_tag.idx);
    assign wr_data_o         = result_i;

    // Last write of the run is on its way out
    assign retire_o = out_tag.strobe && out_tag.last;

    // No strobe may sit behind the last entry of a run
    a_line_empty_after_last: assert property (@(posedge clk) disable iff (!reset_n)
        retire_o |-> (!dly_q[0].strobe && !dly_q[1].strobe))
        else $error("write pending behind the last write of a run");

endmodule

`default_nettype wire

//--- rtl/pwo_top.sv
// Pointwise multiply, add and subtract engine for ML-DSA polynomials
// Memories answer reads one cycle later, no back-pressure is supported
// Base addresses, mode and accumulate must stay stable while busy_o is high

`timescale 1ns/10ps
`default_nettype none

module pwo_top (
    input  wire                 clk,
    input  wire                 reset_n,
    input  wire                 zeroize_i,
    input  wire                 enable_i,
    input  pwo_pkg::pwo_mode_t  mode_i,
    input  wire                 accumulate_i,
    input  wire                 sampler_valid_i,
    input  pwo_pkg::mem_addr_t  a_base_i,
    input  pwo_pkg::mem_addr_t  b_base_i,
    input  pwo_pkg::mem_addr_t  c_base_i,
    output pwo_pkg::mem_req_t   a_rd_req_o,
    output pwo_pkg::mem_req_t   b_rd_req_o,
    output pwo_pkg::mem_req_t   c_rd_req_o,
    input  pwo_pkg::mem_word_t  a_rd_data_i,
    input  pwo_pkg::mem_word_t  b_rd_data_i,
    input  pwo_pkg::mem_word_t  c_rd_data_i,
    output pwo_pkg::mem_req_t   wr_req_o,
    output pwo_pkg::mem_word_t  wr_data_o,
    output logic                busy_o,
    output logic                done_o
);

    pwo_pkg::pwo_op_t   op;
    pwo_pkg::issue_t    issue;
    pwo_pkg::mem_word_t result;
    logic               retire;

    pwo_decode u_decode (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize_i),
        .enable_i        (enable_i),
        .mode_i          (mode_i),
        .accumulate_i    (accumulate_i),
        .sampler_valid_i (sampler_valid_i),
        .a_base_i        (a_base_i),
        .b_base_i        (b_base_i),
        .c_base_i        (c_base_i),
        .a_rd_req_o      (a_rd_req_o),
        .b_rd_req_o      (b_rd_req_o),
        .c_rd_req_o      (c_rd_req_o),
        .op_o            (op),
        .issue_o         (issue),
        .busy_o          (busy_o),
        .retire_i        (retire)
    );

    pwo_execute u_execute (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .op_i      (op),
        .a_data_i  (a_rd_data_i),
        .b_data_i  (b_rd_data_i),
        .c_data_i  (c_rd_data_i),
        .result_o  (result)
    );

    pwo_result u_result (
        .clk       (clk),
        .reset_n   (reset_n),
        .zeroize_i (zeroize_i),
        .issue_i   (issue),
        .c_base_i  (c_base_i),
        .result_i  (result),
        .wr_req_o  (wr_req_o),
        .wr_data_o (wr_data_o),
        .retire_o  (retire),
        .done_o    (done_o)
    );

endmodule

`default_nettype wire

//--- verification/pwo_mem_model.sv
// Behavioural memory for the pointwise testbench, reads return one cycle later
// Only addresses below 256 exist and regions must sit on 64 word boundaries
// Keeps the last word read per port and word index for result prediction

`timescale 1ns/10ps
`default_nettype none

`include "pwo_config.svh"

module pwo_mem_model #(
    parameter int SEED = 7857
) (
    input  wire                 clk,
    input  pwo_pkg::mem_req_t   a_rd_req_i,
    input  pwo_pkg::mem_req_t   b_rd_req_i,
    input  pwo_pkg::mem_req_t   c_rd_req_i,
    input  pwo_pkg::mem_req_t   wr_req_i,
    input  pwo_pkg::mem_word_t  wr_data_i,
    input  pwo_pkg::word_idx_t  seen_idx_i,
    output pwo_pkg::mem_word_t  a_rd_data_o,
    output pwo_pkg::mem_word_t  b_rd_data_o,
    output pwo_pkg::mem_word_t  c_rd_data_o,
    output pwo_pkg::mem_word_t  seen_a_o,
    output pwo_pkg::mem_word_t  seen_b_o,
    output pwo_pkg::mem_word_t  seen_c_o
);

    pwo_pkg::mem_word_t mem [256];
    pwo_pkg::mem_word_t seen_a [`PWO_WORDS];
    pwo_pkg::mem_word_t seen_b [`PWO_WORDS];
    pwo_pkg::mem_word_t seen_c [`PWO_WORDS];
    int                 seed = SEED;

    // Every lane of every word gets its own value below q
    initial begin
        for (int w = 0; w < 256; w++) begin
            for (int i = 0; i < `PWO_LANES; i++) begin
                mem[w][i*`PWO_REG_W +: `PWO_REG_W] =
                    {1'b0, pwo_pkg::coeff_t'({$random(seed)} % 32'(`PWO_Q))};
            end
        end
        for (int k = 0; k < `PWO_WORDS; k++) begin
            seen_a[k] = '0;
            seen_b[k] = '0;
            seen_c[k] = '0;
        end
        a_rd_data_o = '0;
        b_rd_data_o = '0;
        c_rd_data_o = '0;
    end

    always @(posedge clk) begin
        if (a_rd_req_i.rd_wr_en == pwo_pkg::rw_read) begin
            a_rd_data_o                    <= mem[a_rd_req_i.addr[7:0]];
            seen_a[a_rd_req_i.addr[5:0]]   <= mem[a_rd_req_i.addr[7:0]];
        end
        if (b_rd_req_i.rd_wr_en == pwo_pkg::rw_read) begin
            b_rd_data_o                    <= mem[b_rd_req_i.addr[7:0]];
            seen_b[b_rd_req_i.addr[5:0]]   <= mem[b_rd_req_i.addr[7:0]];
        end
        if (c_rd_req_i.rd_wr_en == pwo_pkg::rw_read) begin
            c_rd_data_o                    <= mem[c_rd_req_i.addr[7:0]];
            seen_c[c_rd_req_i.addr[5:0]]   <= mem[c_rd_req_i.addr[7:0]];
        end
        // Same cycle read of a written address returns the old word
        if (wr_req_i.rd_wr_en == pwo_pkg::rw_write) begin
            mem[wr_req_i.addr[7:0]] <= wr_data_i;
        end
    end

    assign seen_a_o = seen_a[seen_idx_i];
    assign seen_b_o = seen_b[seen_idx_i];
    assign seen_c_o = seen_c[seen_idx_i];

endmodule

`default_nettype wire

//--- verification/pwo_tb.sv
// Testbench for pwo_top, every check is a concurrent assertion
// Base addresses must be multiples of 64 below 256 to match the memory model
// Mode and accumulate stay on their run values until the next start

`timescale 1ns/10ps
`default_nettype none

`include "pwo_config.svh"

module pwo_tb;

    localparam int     RUNS       = 6;
    localparam int     RUN_CYCLES = 80;
    localparam int     TIMEOUT_NS = RUNS * RUN_CYCLES * 10 + 2000;
    localparam longint Q          = longint'(`PWO_Q);

    logic               clk = 1'b0;
    logic               reset_n;
    logic               zeroize;
    logic               enable;
    pwo_pkg::pwo_mode_t mode;
    logic               accumulate;
    logic               sampler_valid;
    pwo_pkg::mem_addr_t a_base;
    pwo_pkg::mem_addr_t b_base;
    pwo_pkg::mem_addr_t c_base;
    pwo_pkg::mem_req_t  a_rd_req;
    pwo_pkg::mem_req_t  b_rd_req;
    pwo_pkg::mem_req_t  c_rd_req;
    pwo_pkg::mem_req_t  wr_req;
    pwo_pkg::mem_word_t a_rd_data;
    pwo_pkg::mem_word_t b_rd_data;
    pwo_pkg::mem_word_t c_rd_data;
    pwo_pkg::mem_word_t wr_data;
    pwo_pkg::mem_word_t seen_a;
    pwo_pkg::mem_word_t seen_b;
    pwo_pkg::mem_word_t seen_c;
    pwo_pkg::mem_word_t expected;
    logic               busy;
    logic               done;
    logic               started;
    logic               a_read;
    logic               b_read;
    logic               c_read;
    logic               write;
    logic [63:0]        written = '0;
    int                 write_count = 0;
    int                 seed = 7857;

    always #5 clk = ~clk;

    pwo_top uut (
        .clk             (clk),
        .reset_n         (reset_n),
        .zeroize_i       (zeroize),
        .enable_i        (enable),
        .mode_i          (mode),
        .accumulate_i    (accumulate),
        .sampler_valid_i (sampler_valid),
        .a_base_i        (a_base),
        .b_base_i        (b_base),
        .c_base_i        (c_base),
        .a_rd_req_o      (a_rd_req),
        .b_rd_req_o      (b_rd_req),
        .c_rd_req_o      (c_rd_req),
        .a_rd_data_i     (a_rd_data),
        .b_rd_data_i     (b_rd_data),
        .c_rd_data_i     (c_rd_data),
        .wr_req_o        (wr_req),
        .wr_data_o       (wr_data),
        .busy_o          (busy),
        .done_o          (done)
    );

    pwo_mem_model #(.SEED(7857)) u_mem (
        .clk         (clk),
        .a_rd_req_i  (a_rd_req),
        .b_rd_req_i  (b_rd_req),
        .c_rd_req_i  (c_rd_req),
        .wr_req_i    (wr_req),
        .wr_data_i   (wr_data),
        .seen_idx_i  (wr_req.addr[5:0]),
        .a_rd_data_o (a_rd_data),
        .b_rd_data_o (b_rd_data),
        .c_rd_data_o (c_rd_data),
        .seen_a_o    (seen_a),
        .seen_b_o    (seen_b),
        .seen_c_o    (seen_c)
    );

    // ==========================================================================
    // Reference rules
    // ==========================================================================

    function automatic pwo_pkg::coeff_t predict_lane(input pwo_pkg::pwo_mode_t op,
            input logic acc, input longint a, input longint b, input longint c);
        longint r;
        case (op)
            pwo_pkg::pwm: r = (a * b + (acc ? c : 64'sd0)) % Q;
            pwo_pkg::pwa: r = (a + b) % Q;
            default:      r = (a >= b) ? (a - b) : (a - b + Q);
        endcase
        return pwo_pkg::coeff_t'(r);
    endfunction

    function automatic pwo_pkg::mem_word_t predict_word(input pwo_pkg::pwo_mode_t op,
            input logic acc, input pwo_pkg::mem_word_t a, input pwo_pkg::mem_word_t b,
            input pwo_pkg::mem_word_t c);
        pwo_pkg::mem_word_t w;
        for (int i = 0; i < `PWO_LANES; i++) begin
            w[i*`PWO_REG_W +: `PWO_REG_W] = {1'b0, predict_lane(op, acc,
                longint'(a[i*`PWO_REG_W +: `PWO_COEFF_W]),
                longint'(b[i*`PWO_REG_W +: `PWO_COEFF_W]),
                longint'(c[i*`PWO_REG_W +: `PWO_COEFF_W]))};
        end
        return w;
    endfunction

    always_comb expected = predict_word(mode, accumulate, seen_a, seen_b, seen_c);

    assign a_read = (a_rd_req.rd_wr_en == pwo_pkg::rw_read);
    assign b_read = (b_rd_req.rd_wr_en == pwo_pkg::rw_read);
    assign c_read = (c_rd_req.rd_wr_en == pwo_pkg::rw_read);
    assign write  = (wr_req.rd_wr_en == pwo_pkg::rw_write);

    // Writes per run, cleared by an accepted start
    always @(posedge clk) begin
        if (enable && !busy) begin
            write_count <= 0;
            written     <= '0;
        end else if (write) begin
            write_count               <= write_count + 1;
            written[wr_req.addr[5:0]] <= 1'b1;
        end
    end

    task automatic report_failure(input string msg);
        $display("FAIL at %0t ns: %s", $time, msg);
        $display("Test FAILED");
        $fatal(1, "stopped at first error");
    endtask

    // ==========================================================================
    // Checks
    // ==========================================================================

    a_quiet_before_start: assert property (@(posedge clk) disable iff (!reset_n)
        !started |-> (!busy && !done && !a_read && !b_read && !c_read && !write))
        else report_failure("activity before the first start");
    a_ab_together: assert property (@(posedge clk) disable iff (!reset_n)
        (a_read == b_read) && (c_read == (a_read && mode == pwo_pkg::pwm && accumulate)))
        else report_failure("read ports out of step");
    a_same_index: assert property (@(posedge clk) disable iff (!reset_n)
        a_read |-> ((b_rd_req.addr - b_base) == (a_rd_req.addr - a_base)) &&
                   (!c_read || ((c_rd_req.addr - c_base) == (a_rd_req.addr - a_base))))
        else report_failure("read addresses carry different indexes");
    a_write_latency: assert property (@(posedge clk) disable iff (!reset_n)
        write == $past(a_read, 3))
        else report_failure("write not exactly three cycles after its read");
    a_write_addr: assert property (@(posedge clk) disable iff (!reset_n)
        write |-> ((wr_req.addr - c_base) == ($past(a_rd_req.addr, 3) - a_base)))
        else report_failure("write address does not match its read index");
    a_write_data: assert property (@(posedge clk) disable iff (!reset_n)
        write |-> (wr_data == expected))
        else report_failure("written word differs from the predicted result");
    a_write_once: assert property (@(posedge clk) disable iff (!reset_n)
        write |-> !written[wr_req.addr[5:0]])
        else report_failure("index written twice in one run");
    a_done_after_last: assert property (@(posedge clk) disable iff (!reset_n)
        done == ($past(write) && write_count == `PWO_WORDS && &written))
        else report_failure("done does not follow the 64th write by one cycle");
    a_busy_with_done: assert property (@(posedge clk) disable iff (!reset_n)
        $fell(busy) == done)
        else report_failure("busy does not fall with done");

    // ==========================================================================
    // Stimulus
    // ==========================================================================

    task automatic run_op(input pwo_pkg::pwo_mode_t op, input logic acc, input int a_at,
            input int b_at, input int c_at, input logic gaps, input logic poke);
        int cycle;
        cycle         = 0;
        mode          = op;
        accumulate    = acc;
        a_base        = pwo_pkg::mem_addr_t'(a_at);
        b_base        = pwo_pkg::mem_addr_t'(b_at);
        c_base        = pwo_pkg::mem_addr_t'(c_at);
        sampler_valid = 1'b1;
        enable        = 1'b1;
        started       = 1'b1;
        @(negedge clk);
        enable = 1'b0;
        while (!done) begin
            sampler_valid = gaps ? ($random(seed) % 4 != 0) : 1'b1;
            // Extra start in the middle of the run
            enable = poke && (cycle == 20);
            cycle++;
            @(negedge clk);
        end
        enable = 1'b0;
        repeat (2) @(negedge clk);
    endtask

    initial begin
        reset_n       = 1'b0;
        zeroize       = 1'b0;
        enable        = 1'b0;
        mode          = pwo_pkg::pwm;
        accumulate    = 1'b0;
        sampler_valid = 1'b0;
        a_base        = '0;
        b_base        = '0;
        c_base        = '0;
        started       = 1'b0;
        repeat (8) @(negedge clk);
        reset_n = 1'b1;
        repeat (3) @(negedge clk);
        run_op(pwo_pkg::pwm, 1'b0, 0, 64, 128, 1'b0, 1'b0);
        run_op(pwo_pkg::pwm, 1'b1, 0, 64, 128, 1'b0, 1'b0);
        run_op(pwo_pkg::pwa, 1'b0, 64, 128, 192, 1'b0, 1'b0);
        run_op(pwo_pkg::pws, 1'b0, 0, 128, 192, 1'b0, 1'b0);
        run_op(pwo_pkg::pws, 1'b0, 128, 0, 192, 1'b1, 1'b0);
        run_op(pwo_pkg::pwm, 1'b1, 64, 192, 128, 1'b1, 1'b1);
        $display("Test OK");
        $finish;
    end

    initial begin
        #(TIMEOUT_NS);
        $display("Timeout: the runs did not complete within %0d ns", TIMEOUT_NS);
        $display("Test FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

`default_nettype wire

//--- list.f
+incdir+rtl
rtl/pwo_pkg.sv
rtl/pwo_decode.sv
rtl/pwo_execute.sv
rtl/pwo_result.sv
rtl/pwo_top.sv
verification/pwo_mem_model.sv
verification/pwo_tb.sv

//--- Makefile
# Verilator flow for the pointwise engine testbench

VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := pwo_tb
FILELIST  := list.f
OBJ_DIR   := obj_dir
LOG       := sim.log
PASS_MSG  := Test OK

.PHONY: all lint build sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The simulation log decides pass or fail
sim: build
	-./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -q "^$(PASS_MSG)$$" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation failed, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
